// File: ddr4CaFrontEnd.f
+incdir+dv
common/ddr4CaPkg.sv
decode/ddr4CmdDecoder.sv
logic/ddr4BankTracker.sv
logic/ddr4DataStore.sv
logic/ddr4CaFrontEnd.sv
dv/ddr4CaFrontEndTb.sv

// File: run.sh
#!/bin/sh
# Build and run the DDR4 command/address front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -j 0 \
  --top-module ddr4CaFrontEndTb \
  -Mdir "$OBJ" \
  -f ddr4CaFrontEnd.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/Vddr4CaFrontEndTb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
  exit 0
fi

echo "No pass line found in $LOG"
exit 1

// File: dv/ddr4CaTable.svh
`ifndef DDR4_CA_TABLE_SVH
`define DDR4_CA_TABLE_SVH

// Columns: actN, csN, adr pins, {bg, ba} pins, wrData, then the expected
// kind, rank, {bg, ba}, row or column address, seqError and read byte

function automatic void loadDirectedRows();
  // Every opcode on rank 0, then a deselect
  addRow(1'b1, 2'b10, 17'h1C000, 4'h0, 8'h00, CmdNop, 1'b0, 4'h0, 17'h1C000, 1'b0, 8'h00);
  addRow(1'b1, 2'b10, 17'h00123, 4'h6, 8'h00, CmdMrs, 1'b0, 4'h6, 17'h00123, 1'b0, 8'h00);
  addRow(1'b1, 2'b10, 17'h04000, 4'h0, 8'h00, CmdRef, 1'b0, 4'h0, 17'h04000, 1'b0, 8'h00);
  addRow(1'b1, 2'b10, 17'h18400, 4'h0, 8'h00, CmdZqc, 1'b0, 4'h0, 17'h18400, 1'b0, 8'h00);
  addRow(1'b1, 2'b11, 17'h01234, 4'h3, 8'h00, CmdDsel, 1'b0, 4'h3, 17'h01234, 1'b0, 8'h00);
  // Read of a closed, never written bank
  addRow(1'b1, 2'b10, 17'h14005, 4'h0, 8'h00, CmdRd, 1'b0, 4'h0, 17'h14005, 1'b1, 8'h00);
  // Open bank 1 twice, then column traffic
  addRow(1'b0, 2'b10, 17'h0ABCD, 4'h1, 8'h00, CmdAct, 1'b0, 4'h1, 17'h0ABCD, 1'b0, 8'h00);
  addRow(1'b0, 2'b10, 17'h01111, 4'h1, 8'h00, CmdAct, 1'b0, 4'h1, 17'h01111, 1'b1, 8'h00);
  addRow(1'b1, 2'b10, 17'h13803, 4'h1, 8'hA5, CmdWr, 1'b0, 4'h1, 17'h10003, 1'b0, 8'h00);
  addRow(1'b1, 2'b10, 17'h10007, 4'h2, 8'h3C, CmdWr, 1'b0, 4'h2, 17'h10007, 1'b1, 8'h00);
  addRow(1'b1, 2'b10, 17'h14007, 4'h2, 8'h00, CmdRd, 1'b0, 4'h2, 17'h14007, 1'b1, 8'h3C);
  addRow(1'b1, 2'b10, 17'h15003, 4'h1, 8'h00, CmdRd, 1'b0, 4'h1, 17'h14003, 1'b0, 8'hA5);
  // Single-bank and all-bank precharge
  addRow(1'b1, 2'b10, 17'h08000, 4'h1, 8'h00, CmdPre, 1'b0, 4'h1, 17'h08000, 1'b0, 8'h00);
  addRow(1'b1, 2'b10, 17'h14003, 4'h1, 8'h00, CmdRd, 1'b0, 4'h1, 17'h14003, 1'b1, 8'hA5);
  addRow(1'b0, 2'b10, 17'h00777, 4'h5, 8'h00, CmdAct, 1'b0, 4'h5, 17'h00777, 1'b0, 8'h00);
  addRow(1'b0, 2'b10, 17'h1FFFF, 4'h9, 8'h00, CmdAct, 1'b0, 4'h9, 17'h1FFFF, 1'b0, 8'h00);
  addRow(1'b1, 2'b10, 17'h08400, 4'h0, 8'h00, CmdPre, 1'b0, 4'h0, 17'h08400, 1'b0, 8'h00);
  addRow(1'b0, 2'b10, 17'h00001, 4'h5, 8'h00, CmdAct, 1'b0, 4'h5, 17'h00001, 1'b0, 8'h00);
  addRow(1'b1, 2'b10, 17'h10001, 4'h9, 8'h77, CmdWr, 1'b0, 4'h9, 17'h10001, 1'b1, 8'h00);
  // Rank 1 with mirrored pins
  addRow(1'b0, 2'b01, 17'h12151, 4'h9, 8'h00, CmdAct, 1'b1, 4'h6, 17'h108A9, 1'b0, 8'h00);
  addRow(1'b1, 2'b01, 17'h10950, 4'h9, 8'h5A, CmdWr, 1'b1, 4'h6, 17'h100A8, 1'b0, 8'h00);
  addRow(1'b1, 2'b01, 17'h16150, 4'h9, 8'h00, CmdRd, 1'b1, 4'h6, 17'h140A8, 1'b0, 8'h5A);
  addRow(1'b1, 2'b10, 17'h14150, 4'h9, 8'h00, CmdRd, 1'b0, 4'h9, 17'h14150, 1'b1, 8'h00);
  addRow(1'b1, 2'b10, 17'h14001, 4'h9, 8'h00, CmdRd, 1'b0, 4'h9, 17'h14001, 1'b1, 8'h77);
  addRow(1'b1, 2'b01, 17'h08400, 4'h0, 8'h00, CmdPre, 1'b1, 4'h0, 17'h08400, 1'b0, 8'h00);
  addRow(1'b1, 2'b01, 17'h14150, 4'h9, 8'h00, CmdRd, 1'b1, 4'h6, 17'h140A8, 1'b1, 8'h5A);
  // Both selects low goes to rank 0
  addRow(1'b1, 2'b00, 17'h1C000, 4'h0, 8'h00, CmdNop, 1'b0, 4'h0, 17'h1C000, 1'b0, 8'h00);
  addRow(1'b1, 2'b01, 17'h00038, 4'h4, 8'h00, CmdMrs, 1'b1, 4'h8, 17'h00058, 1'b0, 8'h00);
  // ACT through the opcode with actN high
  addRow(1'b1, 2'b10, 17'h0C123, 4'hC, 8'h00, CmdAct, 1'b0, 4'hC, 17'h0C123, 1'b0, 8'h00);
endfunction

`endif

// File: dv/ddr4CaFrontEndTb.sv
`timescale 1ns/1ps

module ddr4CaFrontEndTb import ddr4CaPkg::*; ();

  localparam int ClkPeriod = 40;
  localparam int IdleRows  = 8;

  // One stimulus row with what it should produce
  typedef struct packed {
    caBusT                ca;
    logic [DataWidth-1:0] wr;
    ddrCmdE               kind;
    logic [RankWidth-1:0] rank;
    logic [BankWidth-1:0] bank;
    logic [AdrWidth-1:0]  expAdr;
    logic                 seqErr;
    logic [DataWidth-1:0] rdByte;
  } rowT;

  logic                 c0_ddr4_ck_t;
  logic                 rst;
  caBusT                caBus;
  logic [DataWidth-1:0] wrData;
  logic                 cmdStrobe;
  ddrCmdT               cmdOut;
  logic                 seqError;
  logic                 rdValid;
  logic [DataWidth-1:0] rdData;
  logic                 writeMode;

  rowT         rows[$];
  caBusT       idleBus;
  logic [31:0] lcgState;
  bit          tableReady;
  logic        writeModeExp;
  int          cmdErrors;
  int          flagErrors;
  int          dataErrors;

  ddr4CaFrontEnd uut (
    .c0_ddr4_ck_t (c0_ddr4_ck_t),
    .rst          (rst),
    .caBus        (caBus),
    .wrData       (wrData),
    .cmdStrobe    (cmdStrobe),
    .cmdOut       (cmdOut),
    .seqError     (seqError),
    .rdValid      (rdValid),
    .rdData       (rdData),
    .writeMode    (writeMode)
  );

  initial begin
    c0_ddr4_ck_t = 1'b0;
    forever #(ClkPeriod / 2) c0_ddr4_ck_t = ~c0_ddr4_ck_t;
  end

  // ==========================================================================
  // Table building
  // ==========================================================================

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic void addRow(
    input logic                 actN,
    input logic [RankCount-1:0] csN,
    input logic [AdrWidth-1:0]  adr,
    input logic [BankWidth-1:0] bankPins,
    input logic [DataWidth-1:0] wr,
    input ddrCmdE               kind,
    input logic [RankWidth-1:0] rank,
    input logic [BankWidth-1:0] bank,
    input logic [AdrWidth-1:0]  expAdr,
    input logic                 seqErr,
    input logic [DataWidth-1:0] rdByte
  );
    rowT r;
    r.ca.actN            = actN;
    r.ca.csN             = csN;
    r.ca.adr             = adr;
    {r.ca.bg, r.ca.ba}   = bankPins;
    r.wr                 = wr;
    r.kind               = kind;
    r.rank               = rank;
    r.bank               = bank;
    r.expAdr             = expAdr;
    r.seqErr             = seqErr;
    r.rdByte             = rdByte;
    rows.push_back(r);
  endfunction

  // Rank 0 NOPs and deselects with random address and bank pins
  function automatic void addIdleRows(input int count);
    logic [31:0]          rnd;
    logic [AdrWidth-1:0]  adr;
    logic [RankCount-1:0] csN;
    ddrCmdE               kind;
    for (int i = 0; i < count; i++) begin
      rnd = nextRand();
      adr = {3'b111, rnd[30:17]};
      if (rnd[31]) begin
        csN  = 2'b11;
        kind = CmdDsel;
      end else begin
        csN  = 2'b10;
        kind = CmdNop;
      end
      addRow(1'b1, csN, adr, rnd[16:13], rnd[12:5], kind, 1'b0, rnd[16:13], adr, 1'b0, 8'h00);
    end
  endfunction

  `include "ddr4CaTable.svh"

  // ==========================================================================
  // Reference model and compare tasks
  // ==========================================================================

  function automatic ddrCmdT expectedCmd(input rowT r);
    ddrCmdT c;
    c.kind     = r.kind;
    c.rank     = r.rank;
    c.bank     = r.bank;
    c.row      = r.expAdr;
    c.col      = r.expAdr[ColWidth-1:0];
    c.allBanks = r.expAdr[AllBanksBit];
    return c;
  endfunction

  task automatic checkCmd(input string name, input ddrCmdT got, input ddrCmdT exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h exp 0x%h at %0t", name, got, exp, $time);
      cmdErrors++;
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h exp 0x%h at %0t", name, got, exp, $time);
      flagErrors++;
    end
  endtask

  task automatic checkByte(input string name, input logic [DataWidth-1:0] got,
                           input logic [DataWidth-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h exp 0x%h at %0t", name, got, exp, $time);
      dataErrors++;
    end
  endtask

  // Outputs one cycle after the sampling edge
  task automatic checkDecodeStage(input rowT r);
    logic strobeExp;
    strobeExp = (r.kind != CmdDsel);
    checkFlag("cmdStrobe", cmdStrobe, strobeExp);
    if (strobeExp) begin
      checkCmd("cmdOut", cmdOut, expectedCmd(r));
    end
  endtask

  // Outputs two cycles after the sampling edge
  task automatic checkResultStage(input rowT r);
    logic isRd;
    isRd = (r.kind == CmdRd);
    if (r.kind == CmdWr) begin
      writeModeExp = 1'b1;
    end else if (isRd) begin
      writeModeExp = 1'b0;
    end
    checkFlag("seqError", seqError, r.seqErr);
    checkFlag("rdValid", rdValid, isRd);
    if (isRd) begin
      checkByte("rdData", rdData, r.rdByte);
    end
    checkFlag("writeMode", writeMode, writeModeExp);
  endtask

  // ==========================================================================
  // Stimulus loop
  // ==========================================================================

  initial begin
    idleBus      = '0;
    idleBus.actN = 1'b1;
    idleBus.csN  = 2'b11;
    rst          = 1'b1;
    caBus        = idleBus;
    wrData       = '0;
    cmdErrors    = 0;
    flagErrors   = 0;
    dataErrors   = 0;
    writeModeExp = 1'b0;
    lcgState     = 32'he8aa_7405;
    loadDirectedRows();
    addIdleRows(IdleRows);
    tableReady = 1'b1;
    repeat (2) @(posedge c0_ddr4_ck_t);
    @(negedge c0_ddr4_ck_t);
    rst = 1'b0;
    checkFlag("cmdStrobe", cmdStrobe, 1'b0);
    checkFlag("seqError", seqError, 1'b0);
    checkFlag("rdValid", rdValid, 1'b0);
    checkFlag("writeMode", writeMode, 1'b0);
    for (int k = 0; k < rows.size() + 2; k++) begin
      if (k > 0) begin
        @(negedge c0_ddr4_ck_t);
      end
      if (k >= 1 && k - 1 < rows.size()) begin
        checkDecodeStage(rows[k - 1]);
      end
      if (k >= 2) begin
        checkResultStage(rows[k - 2]);
      end
      if (k < rows.size()) begin
        caBus  = rows[k].ca;
        wrData = rows[k].wr;
      end else begin
        caBus  = idleBus;
        wrData = '0;
      end
    end
    $display("Errors: cmd %0d, flag %0d, data %0d", cmdErrors, flagErrors, dataErrors);
    if (cmdErrors + flagErrors + dataErrors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    wait (tableReady);
    #(ClkPeriod * (rows.size() + 10));
    $display("Watchdog timeout: the stimulus loop did not finish in time");
    $display("Regression failed");
    $finish;
  end

endmodule

// File: logic/ddr4CaFrontEnd.sv
`timescale 1ns/1ps

module ddr4CaFrontEnd import ddr4CaPkg::*; (
  input  logic                 c0_ddr4_ck_t,
  input  logic                 rst,
  input  caBusT                caBus,
  input  logic [DataWidth-1:0] wrData,
  output logic                 cmdStrobe,
  output ddrCmdT               cmdOut,
  output logic                 seqError,
  output logic                 rdValid,
  output logic [DataWidth-1:0] rdData,
  output logic                 writeMode
);

  // Write byte aligned to the command strobe
  logic [DataWidth-1:0] wrDataQ;

  // ==========================================================================
  // Decode stage
  // ==========================================================================

  ddr4CmdDecoder decoder (
    .c0_ddr4_ck_t (c0_ddr4_ck_t),
    .rst          (rst),
    .caBus        (caBus),
    .wrData       (wrData),
    .cmdStrobe    (cmdStrobe),
    .cmdOut       (cmdOut),
    .wrDataQ      (wrDataQ)
  );

  // ==========================================================================
  // Command consumers
  // ==========================================================================

  ddr4BankTracker tracker (
    .c0_ddr4_ck_t (c0_ddr4_ck_t),
    .rst          (rst),
    .cmdStrobe    (cmdStrobe),
    .cmdOut       (cmdOut),
    .seqError     (seqError)
  );

  ddr4DataStore store (
    .c0_ddr4_ck_t (c0_ddr4_ck_t),
    .rst          (rst),
    .cmdStrobe    (cmdStrobe),
    .cmdOut       (cmdOut),
    .wrDataQ      (wrDataQ),
    .rdValid      (rdValid),
    .rdData       (rdData),
    .writeMode    (writeMode)
  );

endmodule

// File: logic/ddr4DataStore.sv
`timescale 1ns/1ps

module ddr4DataStore import ddr4CaPkg::*; (
  input  logic                 c0_ddr4_ck_t,
  input  logic                 rst,
  input  logic                 cmdStrobe,
  input  ddrCmdT               cmdOut,
  input  logic [DataWidth-1:0] wrDataQ,
  output logic                 rdValid,
  output logic [DataWidth-1:0] rdData,
  output logic                 writeMode
);

  logic [DataWidth-1:0]     mem [StoreDepth];
  logic [StoreDepth-1:0]    written;
  logic [StoreAdrWidth-1:0] storeIdx;
  logic                     wrHit;
  logic                     rdHit;

  // Location is rank, bank, then low column bits
  assign storeIdx = {cmdOut.rank, cmdOut.bank, cmdOut.col[ColStoreBits-1:0]};

  assign wrHit = cmdStrobe && (cmdOut.kind == CmdWr);
  assign rdHit = cmdStrobe && (cmdOut.kind == CmdRd);

  // ==========================================================================
  // Storage
  // ==========================================================================

  always_ff @(posedge c0_ddr4_ck_t) begin
    if (wrHit) begin
      mem[storeIdx] <= wrDataQ;
    end
  end

  // Tracks which bytes hold data, others read as zero
  always_ff @(posedge c0_ddr4_ck_t) begin
    if (rst) begin
      written <= '0;
    end else if (wrHit) begin
      written[storeIdx] <= 1'b1;
    end
  end

  always_ff @(posedge c0_ddr4_ck_t) begin
    if (rdHit) begin
      rdData <= written[storeIdx] ? mem[storeIdx] : '0;
    end
  end

  // ==========================================================================
  // Read strobe and bus direction
  // ==========================================================================

  always_ff @(posedge c0_ddr4_ck_t) begin
    if (rst) begin
      rdValid   <= 1'b0;
      writeMode <= 1'b0;
    end else begin
      rdValid <= rdHit;
      if (wrHit) begin
        writeMode <= 1'b1;
      end else if (rdHit) begin
        writeMode <= 1'b0;
      end
    end
  end

endmodule

// File: logic/ddr4BankTracker.sv
`timescale 1ns/1ps

module ddr4BankTracker import ddr4CaPkg::*; (
  input  logic   c0_ddr4_ck_t,
  input  logic   rst,
  input  logic   cmdStrobe,
  input  ddrCmdT cmdOut,
  output logic   seqError
);

  // Open flag per rank and bank
  logic [BankCount-1:0] bankOpen [RankCount];

  logic                 isOpen;
  logic                 actHit;
  logic                 colMiss;

  assign isOpen  = bankOpen[cmdOut.rank][cmdOut.bank];
  assign actHit  = cmdStrobe && (cmdOut.kind == CmdAct) && isOpen;
  assign colMiss = cmdStrobe && (cmdOut.kind == CmdWr || cmdOut.kind == CmdRd) && !isOpen;

  // ==========================================================================
  // Bank state
  // ==========================================================================

  always_ff @(posedge c0_ddr4_ck_t) begin
    if (rst) begin
      for (int r = 0; r < RankCount; r++) begin
        bankOpen[r] <= '0;
      end
    end else if (cmdStrobe) begin
      case (cmdOut.kind)
        CmdAct: begin
          bankOpen[cmdOut.rank][cmdOut.bank] <= 1'b1;
        end
        CmdPre: begin
          if (cmdOut.allBanks) begin
            bankOpen[cmdOut.rank] <= '0;
          end else begin
            bankOpen[cmdOut.rank][cmdOut.bank] <= 1'b0;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // ==========================================================================
  // Sequence check
  // ==========================================================================

  always_ff @(posedge c0_ddr4_ck_t) begin
    if (rst) begin
      seqError <= 1'b0;
    end else begin
      seqError <= actHit || colMiss;
    end
  end

endmodule

// File: decode/ddr4CmdDecoder.sv
`timescale 1ns/1ps

module ddr4CmdDecoder import ddr4CaPkg::*; (
  input  logic                 c0_ddr4_ck_t,
  input  logic                 rst,
  input  caBusT                caBus,
  input  logic [DataWidth-1:0] wrData,
  output logic                 cmdStrobe,
  output ddrCmdT               cmdOut,
  output logic [DataWidth-1:0] wrDataQ
);

  logic                      dsel;
  logic [RankWidth-1:0]      rankSel;
  logic                      mirrorOn;
  logic [AdrWidth-1:0]       adrUnmir;
  logic [AdrWidth-1:0]       adrMasked;
  logic [BankAddrWidth-1:0]  baUnmir;
  logic [BankGroupWidth-1:0] bgUnmir;
  ddrOpE                     op;
  ddrCmdE                    kind;
  ddrCmdT                    cmdNext;

  // ==========================================================================
  // Rank select and mirror undo
  // ==========================================================================

  assign dsel = &caBus.csN;

  // CS0 wins when both are low
  assign rankSel  = caBus.csN[0] ? RankWidth'(1) : RankWidth'(0);
  assign mirrorOn = MirrorRank1 && (rankSel == RankWidth'(1));

  always_comb begin
    adrUnmir = caBus.adr;
    baUnmir  = caBus.ba;
    bgUnmir  = caBus.bg;
    if (mirrorOn) begin
      adrUnmir[3]  = caBus.adr[4];
      adrUnmir[4]  = caBus.adr[3];
      adrUnmir[5]  = caBus.adr[6];
      adrUnmir[6]  = caBus.adr[5];
      adrUnmir[7]  = caBus.adr[8];
      adrUnmir[8]  = caBus.adr[7];
      adrUnmir[11] = caBus.adr[13];
      adrUnmir[13] = caBus.adr[11];
      baUnmir      = {caBus.ba[0], caBus.ba[1]};
      bgUnmir      = {caBus.bg[0], caBus.bg[1]};
    end
  end

  // ==========================================================================
  // Opcode decode
  // ==========================================================================

  assign op = ddrOpE'(adrUnmir[OpLsb +: 3]);

  always_comb begin
    if (dsel) begin
      kind = CmdDsel;
    end else if (!caBus.actN) begin
      kind = CmdAct;
    end else begin
      case (op)
        OpMrs:   kind = CmdMrs;
        OpRef:   kind = CmdRef;
        OpPre:   kind = CmdPre;
        OpAct:   kind = CmdAct;
        OpWr:    kind = CmdWr;
        OpRd:    kind = CmdRd;
        OpZqc:   kind = CmdZqc;
        default: kind = CmdNop;
      endcase
    end
  end

  // Column commands carry BC/AP bits up high, drop them
  always_comb begin
    adrMasked = adrUnmir;
    if (kind == CmdWr || kind == CmdRd) begin
      adrMasked = adrUnmir & RdWrAdrMask;
    end
  end

  always_comb begin
    cmdNext.kind     = kind;
    cmdNext.rank     = rankSel;
    cmdNext.bank     = {bgUnmir, baUnmir};
    cmdNext.row      = adrMasked;
    cmdNext.col      = adrMasked[ColWidth-1:0];
    cmdNext.allBanks = adrMasked[AllBanksBit];
  end

  // ==========================================================================
  // Output register
  // ==========================================================================

  always_ff @(posedge c0_ddr4_ck_t) begin
    if (rst) begin
      cmdStrobe <= 1'b0;
    end else begin
      cmdStrobe <= !dsel;
    end
  end

  // Write data rides along with its command
  always_ff @(posedge c0_ddr4_ck_t) begin
    cmdOut  <= cmdNext;
    wrDataQ <= wrData;
  end

endmodule

// File: common/ddr4CaPkg.sv
package ddr4CaPkg;

  // ==========================================================================
  // Pin and field widths
  // ==========================================================================

  localparam int AdrWidth       = 17;
  localparam int BankGroupWidth = 2;
  localparam int BankAddrWidth  = 2;
  localparam int RankCount      = 2;
  localparam int DataWidth      = 8;
  localparam int ColStoreBits   = 5;

  // Rank 1 sits on the back side of the clamshell
  localparam bit MirrorRank1 = 1'b1;

  localparam int RankWidth = $clog2(RankCount);
  localparam int BankWidth = BankGroupWidth + BankAddrWidth;
  localparam int BankCount = 1 << BankWidth;
  localparam int ColWidth  = 10;

  // Opcode lives on A16..A14 (RAS_n, CAS_n, WE_n)
  localparam int OpLsb = 14;

  // A10 selects all banks on PRE
  localparam int AllBanksBit = 10;

  // Clears A13..A11 for column commands
  localparam logic [AdrWidth-1:0] RdWrAdrMask = 17'h1C7FF;

  // Data store geometry
  localparam int StoreAdrWidth = RankWidth + BankWidth + ColStoreBits;
  localparam int StoreDepth    = 1 << StoreAdrWidth;

  // ==========================================================================
  // Command encodings
  // ==========================================================================

  typedef enum logic [2:0] {
    OpMrs = 3'b000,
    OpRef = 3'b001,
    OpPre = 3'b010,
    OpAct = 3'b011,
    OpWr  = 3'b100,
    OpRd  = 3'b101,
    OpZqc = 3'b110,
    OpNop = 3'b111
  } ddrOpE;

  // Same order as the opcode, with deselect on top
  typedef enum logic [3:0] {
    CmdMrs  = 4'd0,
    CmdRef  = 4'd1,
    CmdPre  = 4'd2,
    CmdAct  = 4'd3,
    CmdWr   = 4'd4,
    CmdRd   = 4'd5,
    CmdZqc  = 4'd6,
    CmdNop  = 4'd7,
    CmdDsel = 4'd8
  } ddrCmdE;

  // ==========================================================================
  // Bundles
  // ==========================================================================

  // Command/address pins as sampled
  typedef struct packed {
    logic                      actN;
    logic [RankCount-1:0]      csN;
    logic [AdrWidth-1:0]       adr;
    logic [BankAddrWidth-1:0]  ba;
    logic [BankGroupWidth-1:0] bg;
  } caBusT;

  // Decoded command, bank is {bg, ba}
  typedef struct packed {
    ddrCmdE                kind;
    logic [RankWidth-1:0]  rank;
    logic [BankWidth-1:0]  bank;
    logic [AdrWidth-1:0]   row;
    logic [ColWidth-1:0]   col;
    logic                  allBanks;
  } ddrCmdT;

endpackage
